//--- common/l1d_pkg.sv
package l1d_pkg;

    // processor side
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // 2-way geometry with 32 sets of 64-byte lines
    localparam int SETS       = 32;
    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 16;

    // tag 31..11, index 10..6 and word 5..2 of the address
    localparam int TAG_W      = 21;
    localparam int INDEX_W    = 5;
    localparam int WORD_OFF_W = 4;

    localparam int TAG_LSB   = 11;
    localparam int INDEX_LSB = 6;
    localparam int WORD_LSB  = 2;

    // tag and index of one line
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

    localparam int LINE_W = 512;

    typedef logic [LINE_W-1:0] line_t;

    // cycles from request rise to ready
    localparam int MEM_LATENCY = 6;

    // upper line address bits alias onto these
    localparam int MEM_LINE_AW = 8;
    localparam int MEM_LINES   = 1 << MEM_LINE_AW;

endpackage

//--- rtl/cpu_req_port.sv
`timescale 1ns/1ps

module cpu_req_port
(
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            req,
    input  logic                            we,
    input  logic [l1d_pkg::ADDR_W-1:0]      addr,
    input  logic [l1d_pkg::WORD_W-1:0]      wdata,
    input  logic                            flush,
    input  logic                            hit,
    input  logic [l1d_pkg::WORD_W-1:0]      word_data,
    output logic                            cpu_rd,
    output logic                            cpu_wr,
    output logic [l1d_pkg::TAG_W-1:0]       tag,
    output logic [l1d_pkg::INDEX_W-1:0]     index,
    output logic [l1d_pkg::WORD_OFF_W-1:0]  word_off,
    output logic [l1d_pkg::WORD_W-1:0]      wdata_q,
    output logic                            flush_q,
    output logic                            busy,
    output logic                            done,
    output logic [l1d_pkg::WORD_W-1:0]      rdata
);

    logic accept;

    assign busy   = cpu_rd | cpu_wr;
    assign done   = hit;          // hit already a single pulse
    assign accept = req & ~busy;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            cpu_rd  <= 1'b0;
            cpu_wr  <= 1'b0;
            flush_q <= 1'b0;
        end
        else
        begin
            if (hit)
            begin
                cpu_rd <= 1'b0;
                cpu_wr <= 1'b0;
            end
            else if (accept)
            begin
                cpu_rd <= ~we;
                cpu_wr <= we;
            end
            flush_q <= flush & ~busy & ~req;   // req wins a tie
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            tag      <= addr[l1d_pkg::TAG_LSB +: l1d_pkg::TAG_W];
            index    <= addr[l1d_pkg::INDEX_LSB +: l1d_pkg::INDEX_W];
            word_off <= addr[l1d_pkg::WORD_LSB +: l1d_pkg::WORD_OFF_W];
            wdata_q  <= wdata;
        end
        // the last cycle before hit is the matching compare
        if (cpu_rd && !hit)
            rdata <= word_data;
    end

endmodule

//--- l1d/l1d_controller.sv
`timescale 1ns/1ps

module l1d_controller
(
    input  logic                         clk,
    input  logic                         nrst,
    input  logic [l1d_pkg::TAG_W-1:0]    tag,
    input  logic [l1d_pkg::INDEX_W-1:0]  index,
    input  logic                         cpu_rd,
    input  logic                         cpu_wr,
    input  logic                         flush,
    input  logic                         mem_ready,
    output logic                         hit,
    output logic                         refill,
    output logic                         update,
    output logic                         mem_rd,
    output logic                         mem_wr,
    output logic [l1d_pkg::TAG_W-1:0]    victim_tag,
    output logic                         way
);

    localparam int LINES = l1d_pkg::SETS * l1d_pkg::WAYS;

    typedef enum logic [1:0]
    {
        S_IDLE       = 2'b00,
        S_COMPARE    = 2'b01,
        S_WRITE_BACK = 2'b10,
        S_ALLOCATE   = 2'b11
    } state_t;

    state_t state;
    state_t next_state;

    logic [l1d_pkg::TAG_W-1:0] tag_arr [LINES];
    logic [LINES-1:0]          valid;
    logic [LINES-1:0]          dirty;
    logic [l1d_pkg::SETS-1:0]  lru;    // way to replace next

    logic                      way_q;
    logic                      sel_way;
    logic                      match0;
    logic                      match1;
    logic                      match;
    logic                      victim_dirty;
    logic [l1d_pkg::INDEX_W:0] slot0;
    logic [l1d_pkg::INDEX_W:0] slot1;
    logic [l1d_pkg::INDEX_W:0] slot_sel;
    logic [l1d_pkg::INDEX_W:0] slot_q;

    assign slot0    = {index, 1'b0};
    assign slot1    = {index, 1'b1};
    assign slot_sel = {index, sel_way};
    assign slot_q   = {index, way_q};

    assign match0 = valid[slot0] && (tag_arr[slot0] == tag);
    assign match1 = valid[slot1] && (tag_arr[slot1] == tag);
    assign match  = match0 | match1;

    // hit way, then a free way, then lru
    always_comb
    begin
        if (match0)
            sel_way = 1'b0;
        else if (match1)
            sel_way = 1'b1;
        else if (!valid[slot0])
            sel_way = 1'b0;
        else if (!valid[slot1])
            sel_way = 1'b1;
        else
            sel_way = lru[index];
    end

    // flushed lines keep a stale dirty bit, so check valid too
    assign victim_dirty = valid[slot_sel] & dirty[slot_sel];

    assign way        = (state == S_COMPARE) ? sel_way : way_q;
    assign victim_tag = tag_arr[{index, way}];

    assign mem_rd = (state == S_ALLOCATE);
    assign mem_wr = (state == S_WRITE_BACK);
    assign refill = (state == S_ALLOCATE) & mem_ready;

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if ((cpu_rd || cpu_wr) && !hit)    // request still held during hit
                    next_state = S_COMPARE;
            end
            S_COMPARE:
            begin
                if (match)
                    next_state = S_IDLE;
                else if (victim_dirty)
                    next_state = S_WRITE_BACK;
                else
                    next_state = S_ALLOCATE;
            end
            S_WRITE_BACK:
            begin
                if (mem_ready)
                    next_state = S_ALLOCATE;
            end
            S_ALLOCATE:
            begin
                if (mem_ready)
                    next_state = S_COMPARE;
            end
            default:
                next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state  <= S_IDLE;
            way_q  <= 1'b0;
            hit    <= 1'b0;
            update <= 1'b0;
            valid  <= '0;
            dirty  <= '0;
            lru    <= '0;
        end
        else
        begin
            state  <= next_state;
            hit    <= (state == S_COMPARE) & match;
            update <= (state == S_COMPARE) & match & cpu_wr;

            if (state == S_COMPARE)
                way_q <= sel_way;

            if (state == S_COMPARE && match)
            begin
                lru[index] <= ~sel_way;
                if (cpu_wr)
                    dirty[slot_sel] <= 1'b1;
            end

            if (state == S_IDLE && flush)
                valid <= '0;     // dirty data dropped
            else if (refill)
            begin
                valid[slot_q] <= 1'b1;
                dirty[slot_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill)
            tag_arr[slot_q] <= tag;
    end

endmodule

//--- l1d/l1d_data_array.sv
`timescale 1ns/1ps

module l1d_data_array
(
    input  logic                            clk,
    input  logic                            nrst,
    input  logic [l1d_pkg::INDEX_W-1:0]     index,
    input  logic                            way,
    input  logic [l1d_pkg::WORD_OFF_W-1:0]  word_off,
    input  logic                            refill,
    input  logic                            update,
    input  logic [l1d_pkg::WORD_W-1:0]      wdata,
    input  mem_pkg::line_t                  mem_rline,
    output logic [l1d_pkg::WORD_W-1:0]      word_data,
    output mem_pkg::line_t                  victim_line
);

    localparam int LINES = l1d_pkg::SETS * l1d_pkg::WAYS;

    mem_pkg::line_t            lines [LINES];
    logic [l1d_pkg::INDEX_W:0] slot;
    mem_pkg::line_t            cur_line;

    assign slot     = {index, way};
    assign cur_line = lines[slot];

    assign word_data   = cur_line[word_off * l1d_pkg::WORD_W +: l1d_pkg::WORD_W];
    assign victim_line = cur_line;   // for write-back

    // no writes while in reset
    always_ff @(posedge clk)
    begin
        if (nrst)
        begin
            if (refill)
                lines[slot] <= mem_rline;
            else if (update)
                lines[slot][word_off * l1d_pkg::WORD_W +: l1d_pkg::WORD_W] <= wdata;
        end
    end

endmodule

//--- rtl/l2_mem_model.sv
`timescale 1ns/1ps

module l2_mem_model
(
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             mem_rd,
    input  logic                             mem_wr,
    input  logic [mem_pkg::MEM_LINE_AW-1:0]  mem_addr,
    input  mem_pkg::line_t                   mem_wline,
    output logic                             mem_ready,
    output mem_pkg::line_t                   mem_rline
);

    localparam int CNT_W = $clog2(mem_pkg::MEM_LATENCY);

    mem_pkg::line_t   mem [mem_pkg::MEM_LINES];
    logic [CNT_W-1:0] cnt;
    logic             served;      // ready already given for this request
    logic             served_wr;
    logic             req_on;
    logic             active;
    logic             fire;

    assign req_on = mem_rd | mem_wr;
    assign active = req_on & ~(served & (served_wr == mem_wr));
    assign fire   = active & (cnt == CNT_W'(mem_pkg::MEM_LATENCY - 1));

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            cnt       <= '0;
            served    <= 1'b0;
            served_wr <= 1'b0;
            mem_ready <= 1'b0;
        end
        else
        begin
            mem_ready <= fire;
            if (fire)
            begin
                cnt       <= '0;
                served    <= 1'b1;
                served_wr <= mem_wr;
            end
            else if (active)
                cnt <= cnt + 1'b1;
            else
            begin
                cnt <= '0;
                if (!req_on)
                    served <= 1'b0;
            end
        end
    end

    // each word starts as its own byte address
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int l = 0; l < mem_pkg::MEM_LINES; l++)
                for (int w = 0; w < l1d_pkg::LINE_WORDS; w++)
                    mem[l][w * l1d_pkg::WORD_W +: l1d_pkg::WORD_W] <=
                        l1d_pkg::WORD_W'((l << l1d_pkg::INDEX_LSB) | (w << l1d_pkg::WORD_LSB));
        end
        else if (fire && mem_wr)
            mem[mem_addr] <= mem_wline;
    end

    always_ff @(posedge clk)
    begin
        if (fire && mem_rd)
            mem_rline <= mem[mem_addr];    // held through the ready cycle
    end

endmodule

//--- rtl/l1d_top.sv
`timescale 1ns/1ps

module l1d_top
(
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        req,
    input  logic                        we,
    input  logic [l1d_pkg::ADDR_W-1:0]  addr,
    input  logic [l1d_pkg::WORD_W-1:0]  wdata,
    input  logic                        flush,
    output logic [l1d_pkg::WORD_W-1:0]  rdata,
    output logic                        done,
    output logic                        busy
);

    logic                                cpu_rd;
    logic                                cpu_wr;
    logic [l1d_pkg::TAG_W-1:0]           tag;
    logic [l1d_pkg::INDEX_W-1:0]         index;
    logic [l1d_pkg::WORD_OFF_W-1:0]      word_off;
    logic [l1d_pkg::WORD_W-1:0]          wdata_q;
    logic                                flush_q;
    logic                                hit;
    logic                                refill;
    logic                                update;
    logic                                way;
    logic [l1d_pkg::TAG_W-1:0]           victim_tag;
    logic [l1d_pkg::WORD_W-1:0]          word_data;
    mem_pkg::line_t                      victim_line;
    mem_pkg::line_t                      mem_rline;
    logic                                mem_rd;
    logic                                mem_wr;
    logic                                mem_ready;
    logic [l1d_pkg::LINE_ADDR_W-1:0]     rd_line;
    logic [l1d_pkg::LINE_ADDR_W-1:0]     wr_line;
    logic [mem_pkg::MEM_LINE_AW-1:0]     mem_addr;

    assign rd_line  = {tag, index};
    assign wr_line  = {victim_tag, index};
    assign mem_addr = mem_wr ? wr_line[mem_pkg::MEM_LINE_AW-1:0]
                             : rd_line[mem_pkg::MEM_LINE_AW-1:0];

    cpu_req_port u_port
    (
        .clk(clk), .nrst(nrst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .flush(flush), .hit(hit), .word_data(word_data), .cpu_rd(cpu_rd),
        .cpu_wr(cpu_wr), .tag(tag), .index(index), .word_off(word_off),
        .wdata_q(wdata_q), .flush_q(flush_q), .busy(busy), .done(done), .rdata(rdata)
    );

    l1d_controller u_ctrl
    (
        .clk(clk), .nrst(nrst), .tag(tag), .index(index), .cpu_rd(cpu_rd),
        .cpu_wr(cpu_wr), .flush(flush_q), .mem_ready(mem_ready), .hit(hit),
        .refill(refill), .update(update), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .victim_tag(victim_tag), .way(way)
    );

    l1d_data_array u_data
    (
        .clk(clk), .nrst(nrst), .index(index), .way(way), .word_off(word_off),
        .refill(refill), .update(update), .wdata(wdata_q), .mem_rline(mem_rline),
        .word_data(word_data), .victim_line(victim_line)
    );

    l2_mem_model u_mem
    (
        .clk(clk), .nrst(nrst), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_wline(victim_line),
        .mem_ready(mem_ready), .mem_rline(mem_rline)
    );

endmodule

//--- dv/l1d_tests.svh
task automatic test_read_miss();
    int          e0;
    logic [31:0] got;
    begin
        e0 = errors;
        run_op(1'b0, 32'h0000_0840, 32'h0, got);    // miss fills the line
        check("rdata", got, 32'h0000_0840);
        run_op(1'b0, 32'h0000_0854, 32'h0, got);
        run_op(1'b0, 32'h0000_087c, 32'h0, got);
        run_op(1'b0, 32'h0000_084c, 32'h0, got);
        finish_test("read_miss", e0);
    end
endtask

task automatic test_write_read();
    int          e0;
    logic [31:0] got;
    begin
        e0 = errors;
        run_op(1'b1, 32'h0000_0890, 32'hcafe_0001, got);    // write miss
        run_op(1'b0, 32'h0000_0890, 32'h0, got);
        check("rdata", got, 32'hcafe_0001);
        run_op(1'b0, 32'h0000_088c, 32'h0, got);
        run_op(1'b0, 32'h0000_0894, 32'h0, got);
        run_op(1'b1, 32'h0000_0890, 32'hcafe_0002, got);    // write hit
        run_op(1'b0, 32'h0000_0890, 32'h0, got);
        finish_test("write_read", e0);
    end
endtask

// tags 1, 2, 3 at index 3
task automatic test_eviction();
    int          e0;
    logic [31:0] got;
    begin
        e0 = errors;
        run_op(1'b1, 32'h0000_08c8, 32'h1234_5678, got);
        run_op(1'b0, 32'h0000_10c8, 32'h0, got);
        run_op(1'b0, 32'h0000_08cc, 32'h0, got);    // hit on A makes B the lru
        run_op(1'b0, 32'h0000_10cc, 32'h0, got);    // hit on B makes A the lru
        run_op(1'b0, 32'h0000_18c8, 32'h0, got);    // evicts dirty A
        run_op(1'b0, 32'h0000_10c8, 32'h0, got);    // B still resident
        check("rdata", got, 32'h0000_10c8);
        run_op(1'b0, 32'h0000_08c8, 32'h0, got);
        check("rdata", got, 32'h1234_5678);
        finish_test("eviction", e0);
    end
endtask

task automatic test_flush();
    int          e0;
    logic [31:0] got;
    begin
        e0 = errors;
        run_op(1'b0, 32'h0000_0900, 32'h0, got);
        run_op(1'b1, 32'h0000_0908, 32'hdead_beef, got);
        run_op(1'b0, 32'h0000_0908, 32'h0, got);
        check("rdata", got, 32'hdead_beef);
        flush_cache();
        run_op(1'b0, 32'h0000_0908, 32'h0, got);    // dirty word was dropped
        check("rdata", got, 32'h0000_0908);
        finish_test("flush", e0);
    end
endtask

// 4 tags over indices 8 to 11
task automatic test_random();
    int          e0;
    int          i;
    logic        wr;
    logic [31:0] a;
    logic [31:0] got;
    begin
        e0 = errors;
        for (i = 0; i < 40; i++)
        begin
            rng = xorshift(rng);
            wr  = rng[0];
            a   = (32'(rng[4:3]) << 11) | ((32'd8 + 32'(rng[6:5])) << 6)
                | (32'(rng[10:7]) << 2);
            rng = xorshift(rng);
            run_op(wr, a, rng, got);
        end
        finish_test("random", e0);
    end
endtask

//--- dv/l1d_tb.sv
`timescale 1ns/1ps

module l1d_tb;

    localparam int N_REQ        = 64;
    localparam int CYCLE_LIMIT  = N_REQ * (3 + 2 * mem_pkg::MEM_LATENCY + 4) + 100;
    localparam int SHADOW_WORDS = 4096;    // test addresses stay below 16 KB
    localparam int LINES        = l1d_pkg::SETS * l1d_pkg::WAYS;

    logic                       clk;
    logic                       nrst;
    logic                       req;
    logic                       we;
    logic [l1d_pkg::ADDR_W-1:0] addr;
    logic [l1d_pkg::WORD_W-1:0] wdata;
    logic                       flush;
    logic [l1d_pkg::WORD_W-1:0] rdata;
    logic                       done;
    logic                       busy;

    int          errors = 0;
    int          checks = 0;
    int          reqs   = 0;
    int          cycles = 0;
    logic [31:0] rng    = 32'h8882_0898;

    // cpu_view is what the processor should read, mem_view what L2 holds
    logic [31:0]               cpu_view [SHADOW_WORDS];
    logic [31:0]               mem_view [SHADOW_WORDS];
    logic [l1d_pkg::TAG_W-1:0] m_tag    [LINES];
    logic [LINES-1:0]          m_valid;
    logic [LINES-1:0]          m_dirty;    // expected dirty lines
    logic [l1d_pkg::SETS-1:0]  m_lru;

    l1d_top uut
    (
        .clk(clk), .nrst(nrst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .flush(flush), .rdata(rdata), .done(done), .busy(busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        begin
            x = s ^ (s << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            return x;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        begin
            checks++;
            if (got !== exp)
            begin
                errors++;
                $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
            end
        end
    endtask

    task automatic move_line(input int line, input bit to_mem);
        int b;
        begin
            b = line * l1d_pkg::LINE_WORDS;
            for (int k = 0; k < l1d_pkg::LINE_WORDS; k++)
            begin
                if (to_mem)
                    mem_view[b + k] = cpu_view[b + k];
                else
                    cpu_view[b + k] = mem_view[b + k];
            end
        end
    endtask

    task automatic model_access(input logic wr, input logic [31:0] a, input logic [31:0] wd,
                                output logic [31:0] exp, output bit is_hit);
        int                        idx;
        logic [l1d_pkg::TAG_W-1:0] tg;
        int                        w;
        int                        s;
        begin
            idx    = a[10:6];
            tg     = a[31:11];
            is_hit = 1'b1;
            if (m_valid[idx * 2] && m_tag[idx * 2] == tg)
                w = 0;
            else if (m_valid[idx * 2 + 1] && m_tag[idx * 2 + 1] == tg)
                w = 1;
            else
            begin
                is_hit = 1'b0;
                if (!m_valid[idx * 2])
                    w = 0;
                else if (!m_valid[idx * 2 + 1])
                    w = 1;
                else
                    w = m_lru[idx];
                s = idx * 2 + w;
                if (m_valid[s] && m_dirty[s])
                    move_line(m_tag[s] * l1d_pkg::SETS + idx, 1'b1);    // write-back
                m_tag[s]   = tg;
                m_valid[s] = 1'b1;
                m_dirty[s] = 1'b0;
            end
            s = idx * 2 + w;
            m_lru[idx] = (w == 0);
            if (wr)
            begin
                m_dirty[s] = 1'b1;
                cpu_view[a[13:2]] = wd;
            end
            exp = cpu_view[a[13:2]];
        end
    endtask

    // drives one request from a falling edge and waits for done
    task automatic run_op(input logic wr, input logic [31:0] a, input logic [31:0] wd,
                          output logic [31:0] got);
        logic [31:0] exp;
        bit          is_hit;
        int          lat;
        begin
            model_access(wr, a, wd, exp, is_hit);
            reqs++;
            req   = 1'b1;
            we    = wr;
            addr  = a;
            wdata = wd;
            @(negedge clk);
            req = 1'b0;
            lat = 1;
            while (!done)
            begin
                check("busy", busy, 32'h1);
                @(negedge clk);
                lat++;
            end
            check("busy", busy, 32'h1);
            got = rdata;
            if (is_hit)
                check("req to done cycles", lat, 32'd3);    // hit latency
            @(negedge clk);
            check("busy", busy, 32'h0);
            check("done", done, 32'h0);
            if (!wr)
                check("rdata", got, exp);
        end
    endtask

    task automatic flush_cache();
        begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            for (int s = 0; s < LINES; s++)
            begin
                if (m_valid[s] && m_dirty[s])
                    move_line(m_tag[s] * l1d_pkg::SETS + s / 2, 1'b0);    // data lost
            end
            m_valid = '0;
            m_dirty = '0;
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        begin
            $display("%s: %s, %0d errors", name, (errors == e0) ? "ok" : "failed", errors - e0);
        end
    endtask

    `include "l1d_tests.svh"

    initial
    begin
        nrst  = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        flush = 1'b0;
        for (int i = 0; i < SHADOW_WORDS; i++)
        begin
            cpu_view[i] = i << 2;
            mem_view[i] = i << 2;
        end
        m_valid = '0;
        m_dirty = '0;
        m_lru   = '0;
        repeat (8) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        test_read_miss();
        test_write_read();
        test_eviction();
        test_flush();
        test_random();

        $display("%0d requests, %0d checks, %0d errors", reqs, checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- l1d_cache.f
+incdir+dv
common/l1d_pkg.sv
common/mem_pkg.sv
rtl/cpu_req_port.sv
l1d/l1d_controller.sv
l1d/l1d_data_array.sv
rtl/l2_mem_model.sv
rtl/l1d_top.sv
dv/l1d_tb.sv
